/* logic/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W          = 32;
    localparam int WORD_W          = 32;
    localparam int BLOCK_W         = 128;
    localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;
    localparam int WAYS            = 4;
    localparam int SETS            = 16;
    localparam int OFFSET_W        = $clog2(BLOCK_W / 8);
    localparam int INDEX_W         = $clog2(SETS);
    localparam int TAG_W           = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W           = $clog2(WAYS);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [WAY_W-1:0]   way_t;
    typedef logic [WAYS-1:0]    way_mask_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL_REQ,
        REFILL_WAIT,
        RESPOND
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    // Word position inside the line, byte offset inside the word dropped
    function automatic logic [$clog2(WORDS_PER_BLOCK)-1:0] addr_word(addr_t addr);
        return addr[$clog2(WORD_W / 8) +: $clog2(WORDS_PER_BLOCK)];
    endfunction

endpackage

/* logic/way_array.sv */
module way_array
    import dcache_pkg::*;
#(
    parameter type T = logic
) (
    input  logic      clk_i,

    // Whole set is read at once
    input  index_t    rd_index_i,
    output T          rd_set_o [WAYS],

    // One or more ways written at a single index
    input  way_mask_t wr_en_i,
    input  index_t    wr_index_i,
    input  T          wr_data_i
);

    T mem [SETS][WAYS];

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_en_i[w]) begin
                mem[wr_index_i][w] <= wr_data_i;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rd_set_o[w] = mem[rd_index_i][w];
        end
    end

endmodule

/* logic/tag_lookup.sv */
module tag_lookup
    import dcache_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,

    input  index_t index_i,
    input  tag_t   tag_i,

    input  logic   fill_i,
    input  way_t   fill_way_i,
    input  logic   mark_dirty_i,
    input  way_t   dirty_way_i,

    output logic   hit_o,
    output way_t   hit_way_o,
    output way_t   victim_way_o,
    output logic   victim_dirty_o,
    output tag_t   victim_tag_o
);

    tag_t      tag_set [WAYS];
    way_mask_t valid_q [SETS];
    way_mask_t dirty_q [SETS];
    way_t      rr_q;
    way_mask_t set_valid;
    way_mask_t set_dirty;
    way_mask_t fill_mask;
    logic      has_invalid;
    way_t      invalid_way;

    way_array #(
        .T (tag_t)
    ) u_tags (
        .clk_i      (clk_i),
        .rd_index_i (index_i),
        .rd_set_o   (tag_set),
        .wr_en_i    (fill_mask),
        .wr_index_i (index_i),
        .wr_data_i  (tag_i)
    );

    assign set_valid = valid_q[index_i];
    assign set_dirty = dirty_q[index_i];
    assign fill_mask = fill_i ? (way_mask_t'(1) << fill_way_i) : '0;

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (set_valid[w] && (tag_set[w] == tag_i)) begin
                hit_o     = 1'b1;
                hit_way_o = way_t'(w);
            end
        end
    end

    // Scan downwards so the lowest invalid way is the one left standing
    always_comb begin
        has_invalid = 1'b0;
        invalid_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                has_invalid = 1'b1;
                invalid_way = way_t'(w);
            end
        end
    end

    assign victim_way_o   = has_invalid ? invalid_way : rr_q;
    assign victim_dirty_o = set_valid[victim_way_o] & set_dirty[victim_way_o];
    assign victim_tag_o   = tag_set[victim_way_o];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rr_q <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index_i][fill_way_i] <= 1'b1;
                dirty_q[index_i][fill_way_i] <= 1'b0;
                rr_q <= rr_q + way_t'(1);
            end
            if (mark_dirty_i) begin
                dirty_q[index_i][dirty_way_i] <= 1'b1;
            end
        end
    end

endmodule

/* logic/line_data.sv */
module line_data
    import dcache_pkg::*;
(
    input  logic                               clk_i,

    input  index_t                             index_i,
    input  logic [$clog2(WORDS_PER_BLOCK)-1:0] word_sel_i,
    input  way_t                               hit_way_i,
    input  way_t                               victim_way_i,

    input  logic                               word_we_i,
    input  word_t                              wdata_i,
    input  logic                               fill_i,
    input  block_t                             fill_data_i,

    output word_t                              rdata_o,
    output block_t                             victim_block_o
);

    block_t    blk_set [WAYS];
    block_t    hit_block;
    block_t    merged_block;
    block_t    wr_block;
    way_mask_t wr_mask;

    way_array #(
        .T (block_t)
    ) u_blocks (
        .clk_i      (clk_i),
        .rd_index_i (index_i),
        .rd_set_o   (blk_set),
        .wr_en_i    (wr_mask),
        .wr_index_i (index_i),
        .wr_data_i  (wr_block)
    );

    assign hit_block      = blk_set[hit_way_i];
    assign rdata_o        = hit_block[word_sel_i * WORD_W +: WORD_W];
    assign victim_block_o = blk_set[victim_way_i];

    always_comb begin
        merged_block = hit_block;
        merged_block[word_sel_i * WORD_W +: WORD_W] = wdata_i;
    end

    // Refill goes to the victim, a word store to the hit way
    always_comb begin
        if (fill_i) begin
            wr_mask  = way_mask_t'(1) << victim_way_i;
            wr_block = fill_data_i;
        end else if (word_we_i) begin
            wr_mask  = way_mask_t'(1) << hit_way_i;
            wr_block = merged_block;
        end else begin
            wr_mask  = '0;
            wr_block = merged_block;
        end
    end

endmodule

/* logic/cache_ctrl.sv */
module cache_ctrl
    import dcache_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               rstn_i,

    // Requester
    input  logic                               req_valid_i,
    input  logic                               req_write_i,
    input  addr_t                              req_addr_i,
    input  word_t                              req_wdata_i,
    output logic                               req_ready_o,
    output logic                               resp_valid_o,
    output word_t                              resp_rdata_o,
    input  logic                               resp_ready_i,

    // Bus
    output logic                               bus_req_valid_o,
    output logic                               bus_req_write_o,
    output addr_t                              bus_req_addr_o,
    output block_t                             bus_req_data_o,
    input  logic                               bus_req_ready_i,
    input  logic                               bus_resp_valid_i,
    input  block_t                             bus_resp_data_i,
    output logic                               bus_resp_ready_o,

    // Lookup results
    input  logic                               hit_i,
    input  logic                               victim_dirty_i,
    input  tag_t                               victim_tag_i,
    input  word_t                              rdata_i,
    input  block_t                             victim_block_i,

    // Lookup address and store write controls
    output index_t                             index_o,
    output tag_t                               tag_o,
    output logic [$clog2(WORDS_PER_BLOCK)-1:0] word_sel_o,
    output logic                               fill_o,
    output logic                               mark_dirty_o,
    output logic                               word_we_o,
    output word_t                              wdata_o,
    output block_t                             fill_data_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic   req_write_q;
    addr_t  req_addr_q;
    word_t  req_wdata_q;
    logic   resp_valid_q;
    word_t  resp_rdata_q;
    logic   bus_req_valid_q;
    logic   bus_req_write_q;
    addr_t  bus_req_addr_q;
    block_t bus_req_data_q;

    logic   req_fire;
    logic   resp_fire;
    logic   bus_req_fire;
    logic   lookup_hit;
    logic   lookup_miss;
    addr_t  line_addr;
    addr_t  wb_addr;

    assign req_ready_o      = (state_q == IDLE);
    assign bus_resp_ready_o = (state_q == REFILL_WAIT);

    assign req_fire     = req_valid_i & req_ready_o;
    assign resp_fire    = resp_valid_q & resp_ready_i;
    assign bus_req_fire = bus_req_valid_q & bus_req_ready_i;
    assign lookup_hit   = (state_q == LOOKUP) & hit_i;
    assign lookup_miss  = (state_q == LOOKUP) & ~hit_i;

    assign line_addr = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wb_addr   = {victim_tag_i, addr_index(req_addr_q), {OFFSET_W{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_fire) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = req_write_q ? IDLE : RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = WRITE_BACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITE_BACK: begin
                if (bus_req_fire) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (bus_req_fire) begin
                    state_d = REFILL_WAIT;
                end
            end
            // Back to LOOKUP, which now hits on the new line
            REFILL_WAIT: begin
                if (bus_resp_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            RESPOND: begin
                if (resp_fire) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q         <= IDLE;
            resp_valid_q    <= 1'b0;
            bus_req_valid_q <= 1'b0;
            bus_req_write_q <= 1'b0;
        end else begin
            state_q <= state_d;

            if (lookup_hit && !req_write_q) begin
                resp_valid_q <= 1'b1;
            end else if (resp_fire) begin
                resp_valid_q <= 1'b0;
            end

            if (lookup_miss) begin
                bus_req_valid_q <= 1'b1;
                bus_req_write_q <= victim_dirty_i;
            end else if (bus_req_fire) begin
                // An accepted write-back rolls straight into the refill read
                bus_req_valid_q <= bus_req_write_q;
                bus_req_write_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
        end
        if (lookup_hit && !req_write_q) begin
            resp_rdata_q <= rdata_i;
        end
        if (lookup_miss) begin
            bus_req_addr_q <= victim_dirty_i ? wb_addr : line_addr;
            bus_req_data_q <= victim_block_i;
        end else if (bus_req_fire && bus_req_write_q) begin
            bus_req_addr_q <= line_addr;
        end
    end

    assign resp_valid_o    = resp_valid_q;
    assign resp_rdata_o    = resp_rdata_q;
    assign bus_req_valid_o = bus_req_valid_q;
    assign bus_req_write_o = bus_req_write_q;
    assign bus_req_addr_o  = bus_req_addr_q;
    assign bus_req_data_o  = bus_req_data_q;

    assign index_o      = addr_index(req_addr_q);
    assign tag_o        = addr_tag(req_addr_q);
    assign word_sel_o   = addr_word(req_addr_q);
    assign word_we_o    = lookup_hit & req_write_q;
    assign mark_dirty_o = lookup_hit & req_write_q;
    assign wdata_o      = req_wdata_q;
    assign fill_o       = bus_resp_ready_o & bus_resp_valid_i;
    assign fill_data_o  = bus_resp_data_i;

endmodule

/* logic/dcache_top.sv */
module dcache_top
    import dcache_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,

    input  logic   req_valid_i,
    input  logic   req_write_i,
    input  addr_t  req_addr_i,
    input  word_t  req_wdata_i,
    output logic   req_ready_o,
    output logic   resp_valid_o,
    output word_t  resp_rdata_o,
    input  logic   resp_ready_i,

    output logic   bus_req_valid_o,
    output logic   bus_req_write_o,
    output addr_t  bus_req_addr_o,
    output block_t bus_req_data_o,
    input  logic   bus_req_ready_i,
    input  logic   bus_resp_valid_i,
    input  block_t bus_resp_data_i,
    output logic   bus_resp_ready_o
);

    logic                               hit;
    way_t                               hit_way;
    way_t                               victim_way;
    logic                               victim_dirty;
    tag_t                               victim_tag;
    word_t                              rdata;
    block_t                             victim_block;
    index_t                             index;
    tag_t                               tag;
    logic [$clog2(WORDS_PER_BLOCK)-1:0] word_sel;
    logic                               fill;
    logic                               mark_dirty;
    logic                               word_we;
    word_t                              wdata;
    block_t                             fill_data;

    cache_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .req_valid_i      (req_valid_i),
        .req_write_i      (req_write_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .resp_ready_i     (resp_ready_i),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_write_o  (bus_req_write_o),
        .bus_req_addr_o   (bus_req_addr_o),
        .bus_req_data_o   (bus_req_data_o),
        .bus_req_ready_i  (bus_req_ready_i),
        .bus_resp_valid_i (bus_resp_valid_i),
        .bus_resp_data_i  (bus_resp_data_i),
        .bus_resp_ready_o (bus_resp_ready_o),
        .hit_i            (hit),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .rdata_i          (rdata),
        .victim_block_i   (victim_block),
        .index_o          (index),
        .tag_o            (tag),
        .word_sel_o       (word_sel),
        .fill_o           (fill),
        .mark_dirty_o     (mark_dirty),
        .word_we_o        (word_we),
        .wdata_o          (wdata),
        .fill_data_o      (fill_data)
    );

    // Refill lands in the victim way, a store dirties the hit way
    tag_lookup u_tag_lookup (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .index_i        (index),
        .tag_i          (tag),
        .fill_i         (fill),
        .fill_way_i     (victim_way),
        .mark_dirty_i   (mark_dirty),
        .dirty_way_i    (hit_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    line_data u_line_data (
        .clk_i          (clk_i),
        .index_i        (index),
        .word_sel_i     (word_sel),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .word_we_i      (word_we),
        .wdata_i        (wdata),
        .fill_i         (fill),
        .fill_data_i    (fill_data),
        .rdata_o        (rdata),
        .victim_block_o (victim_block)
    );

endmodule

/* test/clk_rst_gen.sv */
module clk_rst_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rstn_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge, like any other stimulus
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

/* test/dcache_tb.sv */
module dcache_tb
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED          = 32'h3194_e15e;
    localparam int          N_RANDOM      = 300;
    localparam int          CYCLES_PER_OP = 50;
    localparam int          MAX_CYCLES    = (N_RANDOM + 100) * CYCLES_PER_OP;

    logic   clk;
    logic   rstn;
    logic   req_valid;
    logic   req_write;
    addr_t  req_addr;
    word_t  req_wdata;
    logic   req_ready;
    logic   resp_valid;
    word_t  resp_rdata;
    logic   resp_ready;
    logic   bus_req_valid;
    logic   bus_req_write;
    addr_t  bus_req_addr;
    block_t bus_req_data;
    logic   bus_req_ready;
    logic   bus_resp_valid;
    block_t bus_resp_data;
    logic   bus_resp_ready;

    // Main memory by line address, and the expected word seen by the requester
    block_t      mem [logic [27:0]];
    word_t       shadow [logic [29:0]];
    logic [31:0] rng = SEED;
    int          cyc = 0;
    int          bus_reads = 0;
    int          bus_writes = 0;
    int          bus_ops = 0;
    int          last_wr_op = 0;
    int          last_rd_op = 0;
    addr_t       last_wb_addr;
    block_t      last_wb_data;

    clk_rst_gen u_clk_rst (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    dcache_top u_dut (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .req_valid_i      (req_valid),
        .req_write_i      (req_write),
        .req_addr_i       (req_addr),
        .req_wdata_i      (req_wdata),
        .req_ready_o      (req_ready),
        .resp_valid_o     (resp_valid),
        .resp_rdata_o     (resp_rdata),
        .resp_ready_i     (resp_ready),
        .bus_req_valid_o  (bus_req_valid),
        .bus_req_write_o  (bus_req_write),
        .bus_req_addr_o   (bus_req_addr),
        .bus_req_data_o   (bus_req_data),
        .bus_req_ready_i  (bus_req_ready),
        .bus_resp_valid_i (bus_resp_valid),
        .bus_resp_data_i  (bus_resp_data),
        .bus_resp_ready_o (bus_resp_ready)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // First touch of a line gives memory and shadow the same random contents
    function automatic void touch_line(input addr_t a);
        logic [27:0] line;
        block_t      blk;
        line = a[31:4];
        if (!mem.exists(line)) begin
            for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                blk[w*WORD_W +: WORD_W] = next_rand();
                shadow[{line, 2'(w)}] = blk[w*WORD_W +: WORD_W];
            end
            mem[line] = blk;
        end
    endfunction

    function automatic block_t shadow_block(input addr_t a);
        block_t blk;
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            blk[w*WORD_W +: WORD_W] = shadow[{a[31:4], 2'(w)}];
        end
        return blk;
    endfunction

    task automatic send_req(input logic wr, input addr_t a, input word_t d, output int acc);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= a;
        req_wdata <= d;
        do @(negedge clk); while (!req_ready);
        acc = cyc + 1;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_read(output word_t data, output int done);
        do @(negedge clk); while (!resp_valid);
        data = resp_rdata;
        done = cyc + 1;
    endtask

    task automatic wait_write(output int done);
        do @(negedge clk); while (!req_ready);
        done = cyc + 1;
    endtask

    task automatic read_and_check(input addr_t a, output int lat);
        int    acc;
        int    done;
        word_t data;
        touch_line(a);
        send_req(1'b0, a, '0, acc);
        wait_read(data, done);
        check_value("resp_rdata_o", 128'(data), 128'(shadow[a[31:2]]));
        lat = done - acc;
    endtask

    task automatic write_word(input addr_t a, input word_t d, output int lat);
        int acc;
        int done;
        touch_line(a);
        send_req(1'b1, a, d, acc);
        wait_write(done);
        shadow[a[31:2]] = d;
        lat = done - acc;
    endtask

    task automatic test_read_miss_hits();
        addr_t a;
        int    lat;
        int    rd0;
        a   = 32'h0000_1000;
        rd0 = bus_reads;
        read_and_check(a, lat);
        check_value("bus read count", 128'(bus_reads), 128'(rd0 + 1));
        check_value("bus write count", 128'(bus_writes), 128'd0);
        for (int w = 1; w < WORDS_PER_BLOCK; w++) begin
            read_and_check(a + addr_t'(4 * w), lat);
            check_value("read hit latency", 128'(lat), 128'd2);
        end
        check_value("bus read count", 128'(bus_reads), 128'(rd0 + 1));
    endtask

    task automatic test_write_hit();
        int lat;
        int ops0;
        ops0 = bus_ops;
        write_word(32'h0000_1004, 32'hcafe_0001, lat);
        check_value("write hit latency", 128'(lat), 128'd2);
        read_and_check(32'h0000_1004, lat);
        read_and_check(32'h0000_1000, lat);
        read_and_check(32'h0000_1008, lat);
        read_and_check(32'h0000_100c, lat);
        check_value("bus transfer count", 128'(bus_ops), 128'(ops0));
    endtask

    task automatic test_dirty_eviction();
        addr_t  lines [WAYS];
        addr_t  fifth;
        block_t exp_blk;
        int     vi;
        int     lat;
        int     rd0;
        int     wr0;
        for (int i = 0; i < WAYS; i++) begin
            lines[i] = {24'(32'h200 + i), 4'h5, 4'h0};
            write_word(lines[i] + addr_t'(4 * i), 32'hd000_0000 + i, lat);
        end
        check_value("bus write count", 128'(bus_writes), 128'd0);
        // Ways filled in order, so the round-robin pointer names the victim
        vi      = bus_reads % WAYS;
        exp_blk = shadow_block(lines[vi]);
        fifth   = {24'h000300, 4'h5, 4'h0};
        rd0     = bus_reads;
        wr0     = bus_writes;
        read_and_check(fifth, lat);
        check_value("bus write count", 128'(bus_writes), 128'(wr0 + 1));
        check_value("bus read count", 128'(bus_reads), 128'(rd0 + 1));
        check_value("bus_req_addr_o", 128'(last_wb_addr), 128'(lines[vi]));
        check_value("bus_req_data_o", last_wb_data, exp_blk);
        check_value("write-back before refill", 128'(last_wr_op < last_rd_op), 128'd1);
        read_and_check(lines[vi] + addr_t'(4 * vi), lat);
        check_value("bus read count", 128'(bus_reads), 128'(rd0 + 2));
    endtask

    task automatic test_resp_backpressure();
        addr_t a;
        word_t data;
        int    acc;
        int    done;
        a = 32'h0000_1008;
        touch_line(a);
        @(posedge clk);
        resp_ready <= 1'b0;
        send_req(1'b0, a, '0, acc);
        wait_read(data, done);
        check_value("resp_rdata_o", 128'(data), 128'(shadow[a[31:2]]));
        repeat (6) begin
            @(negedge clk);
            check_value("resp_valid_o", 128'(resp_valid), 128'd1);
            check_value("resp_rdata_o", 128'(resp_rdata), 128'(data));
            check_value("req_ready_o", 128'(req_ready), 128'd0);
        end
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("resp_valid_o", 128'(resp_valid), 128'd0);
    endtask

    // 64 lines over 8 sets, so sets overflow and dirty lines get evicted
    task automatic test_random_mix();
        logic [5:0]  ln;
        logic [1:0]  wd;
        logic [31:0] r;
        addr_t       a;
        int          lat;
        for (int i = 0; i < N_RANDOM; i++) begin
            ln = 6'((next_rand() >> 16) % 64);
            wd = 2'(next_rand() >> 16);
            a  = 32'h0004_0000 + (addr_t'(ln[5:3]) << 8) + (addr_t'(ln[2:0]) << 4)
                 + (addr_t'(wd) << 2);
            r  = next_rand();
            if (r[31]) begin
                write_word(a, next_rand(), lat);
            end else begin
                read_and_check(a, lat);
            end
        end
    endtask

    // Memory side of the bus with random accept and response delays
    initial begin : bus_model
        int     delay;
        logic   wr;
        addr_t  addr;
        block_t data;
        bus_req_ready  = 1'b0;
        bus_resp_valid = 1'b0;
        bus_resp_data  = '0;
        forever begin
            @(negedge clk);
            if (bus_req_valid) begin
                delay = int'((next_rand() >> 16) % 4);
                repeat (delay) @(negedge clk);
                wr   = bus_req_write;
                addr = bus_req_addr;
                data = bus_req_data;
                check_value("bus_req_addr_o[3:0]", 128'(addr[3:0]), 128'd0);
                @(posedge clk);
                bus_req_ready <= 1'b1;
                @(posedge clk);
                bus_req_ready <= 1'b0;
                bus_ops++;
                if (wr) begin
                    mem[addr[31:4]] = data;
                    bus_writes++;
                    last_wr_op   = bus_ops;
                    last_wb_addr = addr;
                    last_wb_data = data;
                end else begin
                    bus_reads++;
                    last_rd_op = bus_ops;
                    touch_line(addr);
                    delay = int'((next_rand() >> 16) % 4);
                    repeat (delay) @(posedge clk);
                    bus_resp_valid <= 1'b1;
                    bus_resp_data  <= mem[addr[31:4]];
                    do @(negedge clk); while (!bus_resp_ready);
                    @(posedge clk);
                    bus_resp_valid <= 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: no finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b1;
        wait (rstn);
        @(negedge clk);
        check_value("req_ready_o", 128'(req_ready), 128'd1);
        check_value("resp_valid_o", 128'(resp_valid), 128'd0);
        check_value("bus_req_valid_o", 128'(bus_req_valid), 128'd0);
        check_value("bus_resp_ready_o", 128'(bus_resp_ready), 128'd0);
        test_read_miss_hits();
        test_write_hit();
        test_dirty_eviction();
        test_resp_backpressure();
        test_random_mix();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* sources.f */
logic/dcache_pkg.sv
logic/way_array.sv
logic/tag_lookup.sv
logic/line_data.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
test/clk_rst_gen.sv
test/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
